//--- rtl/debug_mon_settings.svh
`ifndef DEBUG_MON_SETTINGS_SVH
`define DEBUG_MON_SETTINGS_SVH

// --------------------------------------------------
// Cluster dimensions
// --------------------------------------------------

// Harts sharing the retirement bus
`define DBG_NUM_HARTS 4

// PC and instruction word width
`define DBG_XLEN 32

// --------------------------------------------------
// Instruction encodings
// --------------------------------------------------

// ebreak, full 32-bit word
`define DBG_EBREAK_OPC 32'h0010_0073

// c.ebreak sits in the low half, upper half zero
`define DBG_CEBREAK_OPC 32'h0000_9002

// dret, only legal in debug mode
`define DBG_DRET_OPC 32'h7b20_0073

`endif

//--- rtl/debug_mon_pkg.sv
`include "debug_mon_settings.svh"

package debug_mon_pkg;

  // --------------------------------------------------
  // Data widths
  // --------------------------------------------------

  typedef logic [`DBG_XLEN-1:0] addr_t;
  typedef logic [`DBG_XLEN-1:0] instr_t;

  // Enough for four harts
  typedef logic [1:0] hart_id_t;

  // --------------------------------------------------
  // Encodings
  // --------------------------------------------------

  // Matches the dcsr.cause field
  typedef enum logic [2:0] {
    NONE    = 3'd0,
    EBREAK  = 3'd1,
    TRIGGER = 3'd2,
    HALTREQ = 3'd3
  } dbg_cause_e;

  // Listed in reporting priority, first match wins
  typedef enum logic [2:0] {
    V_MISSED_ENTRY,
    V_UNEXPECTED_ENTRY,
    V_WRONG_CAUSE,
    V_WRONG_DPC,
    V_WRONG_HALT_PC,
    V_DRET_NO_EXIT
  } violation_e;

  typedef enum logic [1:0] {
    RUN,
    ENTRY_DUE,
    IN_DEBUG,
    DRET_DUE
  } track_state_e;

  typedef enum logic [1:0] {
    IDLE,
    REQ_HIGH,
    WAIT_RELEASE
  } report_state_e;

endpackage

//--- rtl/retire_event_if.sv
// One classified retirement for a single hart
interface retire_event_if;

  logic                       valid;
  debug_mon_pkg::addr_t       pc;
  logic                       is_ebreak;
  logic                       is_dret;
  logic                       is_compressed;
  logic                       trig_hit;
  logic                       at_halt_addr;

  // Core-reported debug status at this retirement
  logic                       debug_mode;
  debug_mon_pkg::dbg_cause_e  cause;
  debug_mon_pkg::addr_t       dpc;

  modport dec (
    output valid, pc, is_ebreak, is_dret, is_compressed,
    output trig_hit, at_halt_addr,
    output debug_mode, cause, dpc
  );

  modport trk (
    input valid, pc, is_ebreak, is_dret, is_compressed,
    input trig_hit, at_halt_addr,
    input debug_mode, cause, dpc
  );

endinterface

//--- rtl/retire_decoder.sv
`include "debug_mon_settings.svh"

module retire_decoder (
  input  logic                      cov_assert_if,
  input  logic                      rst_n_i,
  input  logic                      ret_valid_i,
  input  debug_mon_pkg::hart_id_t   ret_hart_i,
  input  debug_mon_pkg::instr_t     ret_instr_i,
  input  debug_mon_pkg::addr_t      ret_pc_i,
  input  logic                      ret_debug_mode_i,
  input  debug_mon_pkg::dbg_cause_e ret_cause_i,
  input  debug_mon_pkg::addr_t      ret_dpc_i,
  input  debug_mon_pkg::addr_t      trig_addr_i,
  input  logic                      trig_en_i,
  input  debug_mon_pkg::addr_t      dm_halt_addr_i,
  retire_event_if.dec               ev [`DBG_NUM_HARTS]
);

  logic                      is_ebreak;
  logic                      is_dret;
  logic                      is_compressed;
  logic                      trig_hit;
  logic                      at_halt_addr;
  debug_mon_pkg::addr_t      halt_base;

  logic                      valid_q;
  debug_mon_pkg::hart_id_t   hart_q;
  debug_mon_pkg::addr_t      pc_q;
  logic                      ebreak_q;
  logic                      dret_q;
  logic                      compressed_q;
  logic                      trig_hit_q;
  logic                      halt_addr_q;
  logic                      dmode_q;
  debug_mon_pkg::dbg_cause_e cause_q;
  debug_mon_pkg::addr_t      dpc_q;
  logic [`DBG_NUM_HARTS-1:0] sel_valid;

  // --------------------------------------------------
  // Classification on the raw bus
  // --------------------------------------------------

  assign is_ebreak     = (ret_instr_i == `DBG_EBREAK_OPC) || (ret_instr_i == `DBG_CEBREAK_OPC);
  assign is_dret       = (ret_instr_i == `DBG_DRET_OPC);
  assign is_compressed = (ret_instr_i[1:0] != 2'b11);
  assign trig_hit      = trig_en_i && (ret_pc_i == trig_addr_i);
  // Halt address is word aligned
  assign halt_base     = {dm_halt_addr_i[`DBG_XLEN-1:2], 2'b00};
  assign at_halt_addr  = (ret_pc_i == halt_base);

  always_ff @(posedge cov_assert_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= ret_valid_i;
    end
  end

  always_ff @(posedge cov_assert_if) begin
    if (ret_valid_i) begin
      hart_q       <= ret_hart_i;
      pc_q         <= ret_pc_i;
      ebreak_q     <= is_ebreak;
      dret_q       <= is_dret;
      compressed_q <= is_compressed;
      trig_hit_q   <= trig_hit;
      halt_addr_q  <= at_halt_addr;
      dmode_q      <= ret_debug_mode_i;
      cause_q      <= ret_cause_i;
      dpc_q        <= ret_dpc_i;
    end
  end

  // --------------------------------------------------
  // Steer to the owning hart
  // --------------------------------------------------

  for (genvar g = 0; g < `DBG_NUM_HARTS; g++) begin : g_fanout
    assign sel_valid[g]        = valid_q && (hart_q == debug_mon_pkg::hart_id_t'(g));
    assign ev[g].valid         = sel_valid[g];
    assign ev[g].pc            = pc_q;
    assign ev[g].is_ebreak     = ebreak_q;
    assign ev[g].is_dret       = dret_q;
    assign ev[g].is_compressed = compressed_q;
    assign ev[g].trig_hit      = trig_hit_q;
    assign ev[g].at_halt_addr  = halt_addr_q;
    assign ev[g].debug_mode    = dmode_q;
    assign ev[g].cause         = cause_q;
    assign ev[g].dpc           = dpc_q;
  end

  a_one_hart_per_cycle: assert property (
    @(posedge cov_assert_if) disable iff (!rst_n_i)
    $onehot0(sel_valid)
  ) else $error("More than one hart event in a cycle");

endmodule

//--- rtl/debug_entry_tracker.sv
module debug_entry_tracker (
  input  logic                      cov_assert_if,
  input  logic                      rst_n_i,
  input  logic                      debug_req_i,
  input  logic                      dcsr_ebreakm_i,
  retire_event_if.trk               ev,
  output logic                      viol_valid_o,
  output debug_mon_pkg::violation_e viol_code_o
);

  debug_mon_pkg::track_state_e state_q;
  debug_mon_pkg::track_state_e state_d;
  debug_mon_pkg::dbg_cause_e   exp_cause_q;
  debug_mon_pkg::addr_t        exp_dpc_q;
  debug_mon_pkg::dbg_cause_e   pred_cause;
  debug_mon_pkg::addr_t        pred_dpc;
  logic                        pred_hit;
  logic                        take_pred;
  logic                        halt_pend_q;
  logic                        halt_req;
  logic                        viol_d;
  debug_mon_pkg::violation_e   code_d;

  // A request seen in this cycle counts as well as a latched one
  assign halt_req = halt_pend_q || debug_req_i;

  // --------------------------------------------------
  // Cause prediction, trigger > ebreak > haltreq
  // --------------------------------------------------

  always_comb begin
    pred_hit   = 1'b1;
    pred_cause = debug_mon_pkg::NONE;
    pred_dpc   = ev.pc;
    if (ev.trig_hit) begin
      pred_cause = debug_mon_pkg::TRIGGER;
    end else if (ev.is_ebreak && dcsr_ebreakm_i) begin
      pred_cause = debug_mon_pkg::EBREAK;
    end else if (halt_req) begin
      // Haltreq resumes after the retired instruction
      pred_cause = debug_mon_pkg::HALTREQ;
      pred_dpc   = ev.pc + debug_mon_pkg::addr_t'(ev.is_compressed ? 2 : 4);
    end else begin
      pred_hit = 1'b0;
    end
  end

  // --------------------------------------------------
  // Entry and exit checks
  // --------------------------------------------------

  always_comb begin
    state_d   = state_q;
    take_pred = 1'b0;
    viol_d    = 1'b0;
    code_d    = debug_mon_pkg::V_MISSED_ENTRY;
    if (ev.valid) begin
      case (state_q)
        debug_mon_pkg::RUN: begin
          if (ev.debug_mode) begin
            viol_d  = 1'b1;
            code_d  = debug_mon_pkg::V_UNEXPECTED_ENTRY;
            state_d = debug_mon_pkg::IN_DEBUG;
          end else begin
            take_pred = pred_hit;
          end
        end
        debug_mon_pkg::ENTRY_DUE: begin
          if (!ev.debug_mode) begin
            viol_d  = 1'b1;
            code_d  = debug_mon_pkg::V_MISSED_ENTRY;
            state_d = debug_mon_pkg::RUN;
          end else begin
            viol_d = 1'b1;
            if (ev.cause != exp_cause_q) begin
              code_d = debug_mon_pkg::V_WRONG_CAUSE;
            end else if (ev.dpc != exp_dpc_q) begin
              code_d = debug_mon_pkg::V_WRONG_DPC;
            end else if (!ev.at_halt_addr) begin
              code_d = debug_mon_pkg::V_WRONG_HALT_PC;
            end else begin
              viol_d = 1'b0;
            end
            state_d = ev.is_dret ? debug_mon_pkg::DRET_DUE : debug_mon_pkg::IN_DEBUG;
          end
        end
        debug_mon_pkg::IN_DEBUG: begin
          if (!ev.debug_mode) begin
            state_d   = debug_mon_pkg::RUN;
            take_pred = pred_hit;
          end else if (ev.is_dret) begin
            state_d = debug_mon_pkg::DRET_DUE;
          end
        end
        debug_mon_pkg::DRET_DUE: begin
          if (ev.debug_mode) begin
            viol_d  = 1'b1;
            code_d  = debug_mon_pkg::V_DRET_NO_EXIT;
            state_d = ev.is_dret ? debug_mon_pkg::DRET_DUE : debug_mon_pkg::IN_DEBUG;
          end else begin
            state_d   = debug_mon_pkg::RUN;
            take_pred = pred_hit;
          end
        end
        default: state_d = debug_mon_pkg::RUN;
      endcase
      if (take_pred) begin
        state_d = debug_mon_pkg::ENTRY_DUE;
      end
    end
  end

  always_ff @(posedge cov_assert_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= debug_mon_pkg::RUN;
      halt_pend_q  <= 1'b0;
      viol_valid_o <= 1'b0;
    end else begin
      state_q      <= state_d;
      viol_valid_o <= viol_d;
      // Any predicted entry also serves the halt request
      if (take_pred) begin
        halt_pend_q <= 1'b0;
      end else if (debug_req_i && (state_q == debug_mon_pkg::RUN)) begin
        halt_pend_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge cov_assert_if) begin
    if (take_pred) begin
      exp_cause_q <= pred_cause;
      exp_dpc_q   <= pred_dpc;
    end
    if (viol_d) begin
      viol_code_o <= code_d;
    end
  end

  a_viol_after_event: assert property (
    @(posedge cov_assert_if) disable iff (!rst_n_i)
    viol_valid_o |-> $past(ev.valid)
  ) else $error("Violation pulse without a preceding event");

endmodule

//--- rtl/violation_arbiter.sv
`include "debug_mon_settings.svh"

module violation_arbiter (
  input  logic                      cov_assert_if,
  input  logic                      rst_n_i,
  input  logic [`DBG_NUM_HARTS-1:0] viol_valid_i,
  input  debug_mon_pkg::violation_e viol_code_i [`DBG_NUM_HARTS],
  output logic                      err_req_o,
  input  logic                      err_ack_i,
  output debug_mon_pkg::hart_id_t   err_hart_o,
  output debug_mon_pkg::violation_e err_code_o
);

  debug_mon_pkg::report_state_e state_q;
  debug_mon_pkg::report_state_e state_d;
  logic [`DBG_NUM_HARTS-1:0]    pend_q;
  debug_mon_pkg::violation_e    pend_code_q [`DBG_NUM_HARTS];
  debug_mon_pkg::hart_id_t      last_q;
  debug_mon_pkg::hart_id_t      pick_hart;
  logic                         grant;

  // --------------------------------------------------
  // Round-robin pick after the last reported hart
  // --------------------------------------------------

  always_comb begin
    int idx;
    pick_hart = last_q;
    // Walk from the farthest hart back so the nearest pending one wins
    for (int i = `DBG_NUM_HARTS; i >= 1; i--) begin
      idx = (int'(last_q) + i) % `DBG_NUM_HARTS;
      if (pend_q[idx]) begin
        pick_hart = debug_mon_pkg::hart_id_t'(idx);
      end
    end
  end

  assign grant     = (state_q == debug_mon_pkg::IDLE) && (|pend_q) && !err_ack_i;
  assign err_req_o = (state_q == debug_mon_pkg::REQ_HIGH);

  // Four-phase handshake
  always_comb begin
    state_d = state_q;
    case (state_q)
      debug_mon_pkg::IDLE:         if (grant) state_d = debug_mon_pkg::REQ_HIGH;
      debug_mon_pkg::REQ_HIGH:     if (err_ack_i) state_d = debug_mon_pkg::WAIT_RELEASE;
      debug_mon_pkg::WAIT_RELEASE: if (!err_ack_i) state_d = debug_mon_pkg::IDLE;
      default:                     state_d = debug_mon_pkg::IDLE;
    endcase
  end

  always_ff @(posedge cov_assert_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= debug_mon_pkg::IDLE;
      pend_q  <= '0;
      last_q  <= debug_mon_pkg::hart_id_t'(`DBG_NUM_HARTS - 1);
    end else begin
      state_q <= state_d;
      if (grant) begin
        last_q <= pick_hart;
      end
      for (int h = 0; h < `DBG_NUM_HARTS; h++) begin
        if (grant && (pick_hart == debug_mon_pkg::hart_id_t'(h))) begin
          pend_q[h] <= 1'b0;
        end else if (viol_valid_i[h]) begin
          pend_q[h] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge cov_assert_if) begin
    // Only the first violation of a hart is kept
    for (int h = 0; h < `DBG_NUM_HARTS; h++) begin
      if (viol_valid_i[h] && !pend_q[h]) begin
        pend_code_q[h] <= viol_code_i[h];
      end
    end
    if (grant) begin
      err_hart_o <= pick_hart;
      err_code_o <= pend_code_q[pick_hart];
    end
  end

  a_report_stable: assert property (
    @(posedge cov_assert_if) disable iff (!rst_n_i)
    (err_req_o || err_ack_i) |=> $stable(err_hart_o) && $stable(err_code_o)
  ) else $error("Report data changed during handshake");

  a_req_after_release: assert property (
    @(posedge cov_assert_if) disable iff (!rst_n_i)
    $rose(err_req_o) |-> !$past(err_ack_i)
  ) else $error("Request raised while ack still high");

endmodule

//--- rtl/debug_mon_top.sv
`include "debug_mon_settings.svh"

module debug_mon_top (
  input  logic                      cov_assert_if,
  input  logic                      rst_n_i,
  input  logic                      ret_valid_i,
  input  debug_mon_pkg::hart_id_t   ret_hart_i,
  input  debug_mon_pkg::instr_t     ret_instr_i,
  input  debug_mon_pkg::addr_t      ret_pc_i,
  input  logic                      ret_debug_mode_i,
  input  debug_mon_pkg::dbg_cause_e ret_cause_i,
  input  debug_mon_pkg::addr_t      ret_dpc_i,
  input  debug_mon_pkg::addr_t      trig_addr_i,
  input  logic                      trig_en_i,
  input  debug_mon_pkg::addr_t      dm_halt_addr_i,
  input  logic [`DBG_NUM_HARTS-1:0] debug_req_i,
  input  logic [`DBG_NUM_HARTS-1:0] dcsr_ebreakm_i,
  output logic                      err_req_o,
  input  logic                      err_ack_i,
  output debug_mon_pkg::hart_id_t   err_hart_o,
  output debug_mon_pkg::violation_e err_code_o
);

  retire_event_if            ev [`DBG_NUM_HARTS] ();
  logic [`DBG_NUM_HARTS-1:0] viol_valid;
  debug_mon_pkg::violation_e viol_code [`DBG_NUM_HARTS];

  retire_decoder u_decoder (
    .cov_assert_if    (cov_assert_if),
    .rst_n_i          (rst_n_i),
    .ret_valid_i      (ret_valid_i),
    .ret_hart_i       (ret_hart_i),
    .ret_instr_i      (ret_instr_i),
    .ret_pc_i         (ret_pc_i),
    .ret_debug_mode_i (ret_debug_mode_i),
    .ret_cause_i      (ret_cause_i),
    .ret_dpc_i        (ret_dpc_i),
    .trig_addr_i      (trig_addr_i),
    .trig_en_i        (trig_en_i),
    .dm_halt_addr_i   (dm_halt_addr_i),
    .ev               (ev)
  );

  // One tracker per hart
  for (genvar g = 0; g < `DBG_NUM_HARTS; g++) begin : g_hart
    debug_entry_tracker u_tracker (
      .cov_assert_if  (cov_assert_if),
      .rst_n_i        (rst_n_i),
      .debug_req_i    (debug_req_i[g]),
      .dcsr_ebreakm_i (dcsr_ebreakm_i[g]),
      .ev             (ev[g]),
      .viol_valid_o   (viol_valid[g]),
      .viol_code_o    (viol_code[g])
    );
  end

  violation_arbiter u_arbiter (
    .cov_assert_if (cov_assert_if),
    .rst_n_i       (rst_n_i),
    .viol_valid_i  (viol_valid),
    .viol_code_i   (viol_code),
    .err_req_o     (err_req_o),
    .err_ack_i     (err_ack_i),
    .err_hart_o    (err_hart_o),
    .err_code_o    (err_code_o)
  );

endmodule

//--- verification/tb_debug_mon.sv
`include "debug_mon_settings.svh"

module tb_debug_mon;

  localparam int CLK_PERIOD      = 20;
  localparam int DIRECTED_CYCLES = 600;
  localparam int RANDOM_RETIRES  = 2000;
  localparam int DRAIN_LIMIT     = 100;
  localparam logic [31:0] NOP    = 32'h0000_0013;
  localparam logic [31:0] C_NOP  = 32'h0000_0001;
  localparam logic [31:0] HALT   = 32'h0000_0800;

  logic                      cov_assert_if;
  logic                      rst_n;
  logic                      ret_valid;
  debug_mon_pkg::hart_id_t   ret_hart;
  debug_mon_pkg::instr_t     ret_instr;
  debug_mon_pkg::addr_t      ret_pc;
  logic                      ret_debug_mode;
  debug_mon_pkg::dbg_cause_e ret_cause;
  debug_mon_pkg::addr_t      ret_dpc;
  debug_mon_pkg::addr_t      trig_addr;
  logic                      trig_en;
  logic [`DBG_NUM_HARTS-1:0] debug_req;
  logic [`DBG_NUM_HARTS-1:0] dcsr_ebreakm;
  logic                      err_req;
  logic                      err_ack;
  debug_mon_pkg::hart_id_t   err_hart;
  debug_mon_pkg::violation_e err_code;
  logic                      hold_ack;

  // Reference list of reports, in the order they must appear
  debug_mon_pkg::hart_id_t   exp_hart [32];
  debug_mon_pkg::violation_e exp_code [32];
  int                        exp_n;
  int                        rep_idx;

  debug_mon_top dut (
    .cov_assert_if    (cov_assert_if),
    .rst_n_i          (rst_n),
    .ret_valid_i      (ret_valid),
    .ret_hart_i       (ret_hart),
    .ret_instr_i      (ret_instr),
    .ret_pc_i         (ret_pc),
    .ret_debug_mode_i (ret_debug_mode),
    .ret_cause_i      (ret_cause),
    .ret_dpc_i        (ret_dpc),
    .trig_addr_i      (trig_addr),
    .trig_en_i        (trig_en),
    .dm_halt_addr_i   (HALT),
    .debug_req_i      (debug_req),
    .dcsr_ebreakm_i   (dcsr_ebreakm),
    .err_req_o        (err_req),
    .err_ack_i        (err_ack),
    .err_hart_o       (err_hart),
    .err_code_o       (err_code)
  );

  always #(CLK_PERIOD / 2) cov_assert_if = ~cov_assert_if;

  task automatic check_failed(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    $display("Test failed");
    $fatal(1);
  endtask

  // --------------------------------------------------
  // Checking assertions
  // --------------------------------------------------

  a_expected_report: assert property (
    @(posedge cov_assert_if) disable iff (!rst_n)
    $rose(err_req) |-> (rep_idx < exp_n) && (err_hart == exp_hart[rep_idx])
                       && (err_code == exp_code[rep_idx])
  ) else check_failed("report hart or code differs from the expected one");

  a_req_waits_for_ack: assert property (
    @(posedge cov_assert_if) disable iff (!rst_n)
    (err_req && !err_ack) |=> err_req
  ) else check_failed("err_req dropped before ack");

  a_no_req_during_ack: assert property (
    @(posedge cov_assert_if) disable iff (!rst_n)
    $rose(err_req) |-> !err_ack
  ) else check_failed("err_req rose while ack still high");

  a_data_stable: assert property (
    @(posedge cov_assert_if) disable iff (!rst_n)
    (err_req || err_ack) |=> $stable(err_hart) && $stable(err_code)
  ) else check_failed("report data changed during handshake");

  always @(posedge cov_assert_if) begin
    if (!rst_n) begin
      rep_idx <= 0;
    end else if (err_req && !$past(err_req)) begin
      rep_idx <= rep_idx + 1;
    end
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------

  task automatic expect_report(input int h, input debug_mon_pkg::violation_e code);
    exp_hart[exp_n] = debug_mon_pkg::hart_id_t'(h);
    exp_code[exp_n] = code;
    exp_n++;
  endtask

  task automatic retire(input int h, input logic [31:0] instr, input logic [31:0] pc,
                        input logic dmode, input debug_mon_pkg::dbg_cause_e cause,
                        input logic [31:0] dpc);
    @(posedge cov_assert_if);
    #2;
    ret_valid      = 1'b1;
    ret_hart       = debug_mon_pkg::hart_id_t'(h);
    ret_instr      = instr;
    ret_pc         = pc;
    ret_debug_mode = dmode;
    ret_cause      = cause;
    ret_dpc        = dpc;
    @(posedge cov_assert_if);
    #2;
    ret_valid = 1'b0;
  endtask

  task automatic halt_request(input int h);
    @(posedge cov_assert_if);
    #2;
    debug_req[h] = 1'b1;
    @(posedge cov_assert_if);
    #2;
    debug_req[h] = 1'b0;
  endtask

  // dret in debug mode, then a normal retirement
  task automatic leave_debug(input int h);
    retire(h, `DBG_DRET_OPC, HALT + 4, 1'b1, debug_mon_pkg::NONE, 32'h0);
    retire(h, NOP, 32'h1000, 1'b0, debug_mon_pkg::NONE, 32'h0);
  endtask

  task automatic drain_reports();
    int waited;
    waited = 0;
    repeat (4) @(posedge cov_assert_if);
    while (rep_idx != exp_n || err_req || err_ack) begin
      if (waited >= DRAIN_LIMIT) begin
        check_failed($sformatf("%0d reports seen, %0d expected", rep_idx, exp_n));
      end else begin
        waited++;
        @(posedge cov_assert_if);
      end
    end
    repeat (4) @(posedge cov_assert_if);
    #2;
  endtask

  // Ack responder with random delays on both edges
  initial begin
    err_ack = 1'b0;
    forever begin
      @(posedge cov_assert_if);
      if (err_req && !hold_ack) begin
        repeat ($urandom_range(0, 5)) @(posedge cov_assert_if);
        #2;
        err_ack = 1'b1;
        while (err_req) @(posedge cov_assert_if);
        repeat ($urandom_range(0, 5)) @(posedge cov_assert_if);
        #2;
        err_ack = 1'b0;
      end
    end
  end

  initial begin
    #((DIRECTED_CYCLES + RANDOM_RETIRES * 2) * CLK_PERIOD * 2);
    $display("Timeout: the run did not finish in the expected time");
    $display("Test failed");
    $fatal(1);
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------

  initial begin
    void'($urandom(32'h8f9d));
    cov_assert_if  = 1'b0;
    rst_n          = 1'b0;
    ret_valid      = 1'b0;
    ret_hart       = '0;
    ret_instr      = NOP;
    ret_pc         = '0;
    ret_debug_mode = 1'b0;
    ret_cause      = debug_mon_pkg::NONE;
    ret_dpc        = '0;
    trig_addr      = 32'h300;
    trig_en        = 1'b0;
    debug_req      = '0;
    dcsr_ebreakm   = 4'b0011;
    hold_ack       = 1'b0;
    exp_n          = 0;
    repeat (8) @(posedge cov_assert_if);
    #2;
    rst_n = 1'b1;

    // Ebreak and c.ebreak with ebreakm set, correct entries
    retire(0, `DBG_EBREAK_OPC, 32'h100, 1'b0, debug_mon_pkg::NONE, 32'h0);
    retire(0, NOP, HALT, 1'b1, debug_mon_pkg::EBREAK, 32'h100);
    leave_debug(0);
    retire(0, `DBG_CEBREAK_OPC, 32'h200, 1'b0, debug_mon_pkg::NONE, 32'h0);
    retire(0, NOP, HALT, 1'b1, debug_mon_pkg::EBREAK, 32'h200);
    leave_debug(0);
    // Hart 2 has ebreakm clear, so nothing is predicted
    retire(2, `DBG_EBREAK_OPC, 32'h120, 1'b0, debug_mon_pkg::NONE, 32'h0);
    retire(2, NOP, 32'h124, 1'b0, debug_mon_pkg::NONE, 32'h0);
    drain_reports();

    // Trigger wins over ebreak
    trig_en = 1'b1;
    expect_report(1, debug_mon_pkg::V_WRONG_CAUSE);
    retire(1, `DBG_EBREAK_OPC, 32'h300, 1'b0, debug_mon_pkg::NONE, 32'h0);
    retire(1, NOP, HALT, 1'b1, debug_mon_pkg::EBREAK, 32'h300);
    leave_debug(1);
    trig_en = 1'b0;
    drain_reports();

    // Halt request, wrong dpc, then compressed, then missed entry
    expect_report(2, debug_mon_pkg::V_WRONG_DPC);
    halt_request(2);
    retire(2, NOP, 32'h400, 1'b0, debug_mon_pkg::NONE, 32'h0);
    retire(2, NOP, HALT, 1'b1, debug_mon_pkg::HALTREQ, 32'h408);
    leave_debug(2);
    halt_request(2);
    retire(2, C_NOP, 32'h500, 1'b0, debug_mon_pkg::NONE, 32'h0);
    retire(2, NOP, HALT, 1'b1, debug_mon_pkg::HALTREQ, 32'h502);
    leave_debug(2);
    drain_reports();
    expect_report(2, debug_mon_pkg::V_MISSED_ENTRY);
    halt_request(2);
    retire(2, NOP, 32'h600, 1'b0, debug_mon_pkg::NONE, 32'h0);
    retire(2, NOP, 32'h604, 1'b0, debug_mon_pkg::NONE, 32'h0);
    drain_reports();

    // Unexpected entry, then dret without exit
    expect_report(3, debug_mon_pkg::V_UNEXPECTED_ENTRY);
    retire(3, NOP, HALT, 1'b1, debug_mon_pkg::HALTREQ, 32'h0);
    drain_reports();
    expect_report(3, debug_mon_pkg::V_DRET_NO_EXIT);
    retire(3, `DBG_DRET_OPC, HALT + 4, 1'b1, debug_mon_pkg::NONE, 32'h0);
    retire(3, NOP, HALT + 8, 1'b1, debug_mon_pkg::NONE, 32'h0);
    leave_debug(3);
    drain_reports();

    // Random normal retirements, none may be reported
    dcsr_ebreakm = '0;
    repeat (RANDOM_RETIRES) begin
      retire(int'($urandom_range(0, 3)), $urandom, $urandom, 1'b0,
             debug_mon_pkg::NONE, $urandom);
    end
    drain_reports();

    // Back-pressure burst, last reported hart was 3
    hold_ack = 1'b1;
    expect_report(1, debug_mon_pkg::V_UNEXPECTED_ENTRY);
    expect_report(2, debug_mon_pkg::V_UNEXPECTED_ENTRY);
    expect_report(3, debug_mon_pkg::V_UNEXPECTED_ENTRY);
    expect_report(0, debug_mon_pkg::V_UNEXPECTED_ENTRY);
    retire(1, NOP, HALT, 1'b1, debug_mon_pkg::HALTREQ, 32'h0);
    retire(3, NOP, HALT, 1'b1, debug_mon_pkg::HALTREQ, 32'h0);
    retire(0, NOP, HALT, 1'b1, debug_mon_pkg::HALTREQ, 32'h0);
    retire(2, NOP, HALT, 1'b1, debug_mon_pkg::HALTREQ, 32'h0);
    // Second violation of hart 3 while pending is dropped
    retire(3, `DBG_DRET_OPC, HALT + 4, 1'b1, debug_mon_pkg::NONE, 32'h0);
    retire(3, NOP, HALT + 8, 1'b1, debug_mon_pkg::NONE, 32'h0);
    hold_ack = 1'b0;
    drain_reports();

    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+rtl
rtl/debug_mon_pkg.sv
rtl/retire_event_if.sv
rtl/retire_decoder.sv
rtl/debug_entry_tracker.sv
rtl/violation_arbiter.sv
rtl/debug_mon_top.sv
verification/tb_debug_mon.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_debug_mon
FILELIST  ?= vlog.f
PASS_MSG  := Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
